//--- hdl/uart_dbg_defs.svh
`ifndef UART_DBG_DEFS_SVH
`define UART_DBG_DEFS_SVH

// Serial bit period in clock cycles
`define UART_CLKS_PER_BIT 16

// Host command codes
`define DBG_CMD_READ  8'h11
`define DBG_CMD_WRITE 8'h12
`define DBG_CMD_EXEC  8'h13

// Target reply codes
`define DBG_ACK 8'h06
`define DBG_EOT 8'h04
`define DBG_EOC 8'h14

// Debug memory index width, 256 bytes
`define DBG_MEM_AW 8

`endif

//--- hdl/uart_dbg_pkg.sv
`default_nettype none

package uart_dbg_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] code_t;

  // Engine states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_ACK,
    ST_RD_DATA,
    ST_WR_DATA,
    ST_EOT,
    ST_EOC
  } dbg_state_e;

endpackage

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_defs.svh"

module uart_rx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                rx_i,
  output uart_dbg_pkg::byte_t rx_data_o,
  output logic                rx_valid_o
);

  localparam int unsigned CPB = `UART_CLKS_PER_BIT;
  localparam int unsigned CW  = $clog2(CPB);

  logic [1:0]          sync_q;
  logic                busy_q;
  logic [CW-1:0]       clk_cnt_q;
  // 0 is start, 1 to 8 are data, 9 is stop
  logic [3:0]          bit_cnt_q;
  uart_dbg_pkg::byte_t shift_q;
  logic                sample;

  // Middle of the current bit
  assign sample = busy_q && (clk_cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q     <= 2'b11;
      busy_q     <= 1'b0;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_valid_o <= 1'b0;
      if (!busy_q) begin
        // Falling edge of the start bit
        if (!sync_q[1]) begin
          busy_q    <= 1'b1;
          clk_cnt_q <= CW'(CPB / 2 - 1);
          bit_cnt_q <= '0;
        end
      end else if (!sample) begin
        clk_cnt_q <= clk_cnt_q - 1'b1;
      end else begin
        clk_cnt_q <= CW'(CPB - 1);
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd0 && sync_q[1]) begin
          // Glitch, not a real start bit
          busy_q <= 1'b0;
        end else if (bit_cnt_q == 4'd9) begin
          busy_q     <= 1'b0;
          // Frame with a low stop bit is dropped
          rx_valid_o <= sync_q[1];
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_cnt_q >= 4'd1 && bit_cnt_q <= 4'd8) begin
      shift_q <= {sync_q[1], shift_q[7:1]};
    end
  end

  assign rx_data_o = shift_q;

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_defs.svh"

module uart_tx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  uart_dbg_pkg::byte_t tx_data_i,
  input  logic                tx_start_i,
  output logic                tx_o,
  output logic                tx_busy_o
);

  localparam int unsigned CPB = `UART_CLKS_PER_BIT;
  localparam int unsigned CW  = $clog2(CPB);

  // Stop, data LSB first, start; bit 0 drives the line
  logic [9:0]    frame_q;
  logic [CW-1:0] clk_cnt_q;
  logic [3:0]    bit_cnt_q;
  logic          busy_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      frame_q   <= '1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        frame_q   <= {1'b1, tx_data_i, 1'b0};
        clk_cnt_q <= CW'(CPB - 1);
        bit_cnt_q <= '0;
        busy_q    <= 1'b1;
      end
    end else if (clk_cnt_q != '0) begin
      clk_cnt_q <= clk_cnt_q - 1'b1;
    end else begin
      // Next bit, idle ones fill in behind
      clk_cnt_q <= CW'(CPB - 1);
      frame_q   <= {1'b1, frame_q[9:1]};
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end
  end

  assign tx_o      = frame_q[0];
  assign tx_busy_o = busy_q;

endmodule

`default_nettype wire

//--- hdl/dbg_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_defs.svh"

module dbg_mem (
  input  logic                   clk,
  input  logic [`DBG_MEM_AW-1:0] addr_i,
  input  logic                   we_i,
  input  uart_dbg_pkg::byte_t    wdata_i,
  output uart_dbg_pkg::byte_t    rdata_o
);

  localparam int unsigned DEPTH = 2 ** `DBG_MEM_AW;

  uart_dbg_pkg::byte_t mem_q [DEPTH];

  // Read returns the old contents on a write to the same index
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

//--- hdl/uart_dbg_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_defs.svh"

module uart_dbg_engine (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  uart_dbg_pkg::byte_t    rx_data_i,
  input  logic                   rx_valid_i,
  output uart_dbg_pkg::byte_t    tx_data_o,
  output logic                   tx_start_o,
  input  logic                   tx_busy_i,
  output logic [`DBG_MEM_AW-1:0] mem_addr_o,
  output logic                   mem_we_o,
  output uart_dbg_pkg::byte_t    mem_wdata_o,
  input  uart_dbg_pkg::byte_t    mem_rdata_i,
  output logic                   exec_o,
  output uart_dbg_pkg::addr_t    exec_addr_o,
  input  logic                   eoc_i,
  input  uart_dbg_pkg::code_t    exit_code_i
);

  uart_dbg_pkg::dbg_state_e state_q;
  uart_dbg_pkg::byte_t      cmd_q;
  uart_dbg_pkg::addr_t      addr_q;
  uart_dbg_pkg::addr_t      len_q;
  uart_dbg_pkg::addr_t      cnt_q;
  uart_dbg_pkg::code_t      code_q;
  uart_dbg_pkg::byte_t      tx_data_q;
  uart_dbg_pkg::byte_t      tx_byte;
  logic                     tx_start_q;
  logic                     exec_q;
  logic                     eoc_pend_q;
  logic                     rd_ready_q;
  logic                     tx_free;
  logic                     tx_fire;
  logic                     field_done;
  logic                     data_last;
  logic [1:0]               code_sel;

  // A strobe issued last cycle is not yet visible on busy
  assign tx_free    = !tx_busy_i && !tx_start_q;
  assign field_done = (cnt_q == uart_dbg_pkg::addr_t'(7));
  assign data_last  = (cnt_q + 64'd1 == len_q);
  assign code_sel   = cnt_q[1:0] - 2'd1;

  //////////////////////////////////////////////////////////////////////
  // Reply byte selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_fire = 1'b0;
    tx_byte = `DBG_ACK;
    case (state_q)
      uart_dbg_pkg::ST_ACK: begin
        tx_fire = tx_free;
      end
      uart_dbg_pkg::ST_RD_DATA: begin
        tx_fire = tx_free && rd_ready_q;
        tx_byte = mem_rdata_i;
      end
      uart_dbg_pkg::ST_EOT: begin
        tx_fire = tx_free;
        tx_byte = `DBG_EOT;
      end
      uart_dbg_pkg::ST_EOC: begin
        tx_fire = tx_free;
        // Code byte then the exit code, LSB first
        tx_byte = (cnt_q == '0) ? `DBG_EOC : code_q[8*code_sel +: 8];
      end
      default: begin
        tx_fire = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= uart_dbg_pkg::ST_IDLE;
      cmd_q      <= '0;
      cnt_q      <= '0;
      eoc_pend_q <= 1'b0;
      rd_ready_q <= 1'b0;
      tx_start_q <= 1'b0;
      exec_q     <= 1'b0;
    end else begin
      tx_start_q <= tx_fire;
      exec_q     <= 1'b0;
      case (state_q)
        uart_dbg_pkg::ST_IDLE: begin
          cnt_q <= '0;
          if (rx_valid_i) begin
            cmd_q <= rx_data_i;
            if (rx_data_i == `DBG_CMD_READ || rx_data_i == `DBG_CMD_WRITE ||
                rx_data_i == `DBG_CMD_EXEC) begin
              state_q <= uart_dbg_pkg::ST_ADDR;
            end else if (rx_data_i == `DBG_ACK) begin
              state_q <= uart_dbg_pkg::ST_ACK;
            end
          end else if (eoc_pend_q) begin
            eoc_pend_q <= 1'b0;
            state_q    <= uart_dbg_pkg::ST_EOC;
          end
        end
        uart_dbg_pkg::ST_ADDR: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 64'd1;
            if (field_done) begin
              cnt_q   <= '0;
              state_q <= (cmd_q == `DBG_CMD_EXEC) ? uart_dbg_pkg::ST_ACK
                                                  : uart_dbg_pkg::ST_LEN;
            end
          end
        end
        uart_dbg_pkg::ST_LEN: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 64'd1;
            if (field_done) begin
              cnt_q   <= '0;
              state_q <= uart_dbg_pkg::ST_ACK;
            end
          end
        end
        uart_dbg_pkg::ST_ACK: begin
          rd_ready_q <= 1'b0;
          if (tx_fire) begin
            // Entry strobe lines up with the ACK start
            exec_q <= (cmd_q == `DBG_CMD_EXEC);
            if (cmd_q == `DBG_CMD_READ) begin
              state_q <= (len_q == '0) ? uart_dbg_pkg::ST_EOT : uart_dbg_pkg::ST_RD_DATA;
            end else if (cmd_q == `DBG_CMD_WRITE) begin
              state_q <= (len_q == '0) ? uart_dbg_pkg::ST_EOT : uart_dbg_pkg::ST_WR_DATA;
            end else begin
              state_q <= uart_dbg_pkg::ST_IDLE;
            end
          end
        end
        uart_dbg_pkg::ST_RD_DATA: begin
          if (!rd_ready_q) begin
            // Memory read latency
            rd_ready_q <= 1'b1;
          end else if (tx_fire) begin
            rd_ready_q <= 1'b0;
            cnt_q      <= cnt_q + 64'd1;
            if (data_last) begin
              state_q <= uart_dbg_pkg::ST_EOT;
            end
          end
        end
        uart_dbg_pkg::ST_WR_DATA: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 64'd1;
            if (data_last) begin
              state_q <= uart_dbg_pkg::ST_EOT;
            end
          end
        end
        uart_dbg_pkg::ST_EOT: begin
          if (tx_fire) begin
            state_q <= uart_dbg_pkg::ST_IDLE;
          end
        end
        uart_dbg_pkg::ST_EOC: begin
          if (tx_fire) begin
            cnt_q <= cnt_q + 64'd1;
            if (cnt_q == uart_dbg_pkg::addr_t'(4)) begin
              cnt_q   <= '0;
              state_q <= uart_dbg_pkg::ST_IDLE;
            end
          end
        end
        default: begin
          state_q <= uart_dbg_pkg::ST_IDLE;
        end
      endcase
      // New request wins over the clear in idle
      if (eoc_i) begin
        eoc_pend_q <= 1'b1;
      end
    end
  end

  // Fields shift in LSB first
  always_ff @(posedge clk) begin
    if (tx_fire) begin
      tx_data_q <= tx_byte;
    end
    if (rx_valid_i && state_q == uart_dbg_pkg::ST_ADDR) begin
      addr_q <= {rx_data_i, addr_q[63:8]};
    end
    if (rx_valid_i && state_q == uart_dbg_pkg::ST_LEN) begin
      len_q <= {rx_data_i, len_q[63:8]};
    end
    if (eoc_i) begin
      code_q <= exit_code_i;
    end
  end

  // Memory index wraps modulo the memory size
  assign mem_addr_o  = addr_q[`DBG_MEM_AW-1:0] + cnt_q[`DBG_MEM_AW-1:0];
  assign mem_we_o    = rx_valid_i && (state_q == uart_dbg_pkg::ST_WR_DATA);
  assign mem_wdata_o = rx_data_i;

  assign tx_data_o   = tx_data_q;
  assign tx_start_o  = tx_start_q;
  assign exec_o      = exec_q;
  assign exec_addr_o = addr_q;

endmodule

`default_nettype wire

//--- hdl/uart_dbg_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_defs.svh"

module uart_dbg_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                uart_rx_i,
  output logic                uart_tx_o,
  output logic                exec_o,
  output uart_dbg_pkg::addr_t exec_addr_o,
  input  logic                eoc_i,
  input  uart_dbg_pkg::code_t exit_code_i
);

  uart_dbg_pkg::byte_t    rx_data;
  logic                   rx_valid;
  uart_dbg_pkg::byte_t    tx_data;
  logic                   tx_start;
  logic                   tx_busy;
  logic [`DBG_MEM_AW-1:0] mem_addr;
  logic                   mem_we;
  uart_dbg_pkg::byte_t    mem_wdata;
  uart_dbg_pkg::byte_t    mem_rdata;

  //////////////////////////////////////////////////////////////////////
  // Serial line
  //////////////////////////////////////////////////////////////////////

  uart_rx i_uart_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_data_o  ( rx_data   ),
    .rx_valid_o ( rx_valid  )
  );

  uart_tx i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_start_i ( tx_start  ),
    .tx_o       ( uart_tx_o ),
    .tx_busy_o  ( tx_busy   )
  );

  //////////////////////////////////////////////////////////////////////
  // Debug server and its memory
  //////////////////////////////////////////////////////////////////////

  uart_dbg_engine i_engine (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .rx_data_i   ( rx_data     ),
    .rx_valid_i  ( rx_valid    ),
    .tx_data_o   ( tx_data     ),
    .tx_start_o  ( tx_start    ),
    .tx_busy_i   ( tx_busy     ),
    .mem_addr_o  ( mem_addr    ),
    .mem_we_o    ( mem_we      ),
    .mem_wdata_o ( mem_wdata   ),
    .mem_rdata_i ( mem_rdata   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .eoc_i       ( eoc_i       ),
    .exit_code_i ( exit_code_i )
  );

  dbg_mem i_mem (
    .clk     ( clk       ),
    .addr_i  ( mem_addr  ),
    .we_i    ( mem_we    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

`default_nettype wire

//--- tb/tb_uart_dbg.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_dbg_defs.svh"

module tb_uart_dbg;

  localparam int CPB        = `UART_CLKS_PER_BIT;
  localparam int CLK_PERIOD = 10;
  // Longest wait for one reply byte, in cycles
  localparam int RX_TIMEOUT = 40 * CPB;
  // About 400 bytes of traffic, 10 bits each, with margin
  localparam longint TEST_BYTES  = 400;
  localparam longint WATCHDOG_NS = TEST_BYTES * 10 * CPB * CLK_PERIOD * 3;

  logic                clk;
  logic                rst_n_i;
  logic                uart_rx_i;
  logic                uart_tx_o;
  logic                exec_o;
  uart_dbg_pkg::addr_t exec_addr_o;
  logic                eoc_i;
  uart_dbg_pkg::code_t exit_code_i;

  int                  seed = 32'hca;
  int                  errors = 0;
  int                  frame_errs = 0;
  int                  n_pass = 0;
  int                  n_fail = 0;
  int unsigned         rx_wr = 0;
  int unsigned         rx_rd = 0;
  int                  exec_pulses = 0;
  uart_dbg_pkg::addr_t exec_seen = '0;
  logic [7:0]          rx_log [0:1023];
  logic [7:0]          mon_shift;
  logic [7:0]          payload [0:15];

  uart_dbg_top DUT (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .uart_rx_i   ( uart_rx_i   ),
    .uart_tx_o   ( uart_tx_o   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .eoc_i       ( eoc_i       ),
    .exit_code_i ( exit_code_i )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Line monitors
  //////////////////////////////////////////////////////////////////////

  // Decodes every frame on uart_tx_o into rx_log
  always begin : tx_monitor
    @(negedge clk);
    if (rst_n_i && uart_tx_o == 1'b0) begin
      repeat (CPB / 2) @(negedge clk);
      assert (uart_tx_o === 1'b0) else begin
        $display("Start bit on uart_tx_o did not stay low to its middle");
        frame_errs = frame_errs + 1;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        mon_shift = {uart_tx_o, mon_shift[7:1]};
      end
      repeat (CPB) @(negedge clk);
      assert (uart_tx_o === 1'b1) else begin
        $display("Stop bit on uart_tx_o was low");
        frame_errs = frame_errs + 1;
      end
      rx_log[rx_wr] = mon_shift;
      rx_wr = rx_wr + 1;
    end
  end

  always @(negedge clk) begin
    if (exec_o === 1'b1) begin
      exec_pulses = exec_pulses + 1;
      exec_seen   = exec_addr_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic drive_bit(input logic v);
    @(posedge clk);
    #1;
    uart_rx_i = v;
    repeat (CPB - 1) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
  endtask

  task automatic send_field(input uart_dbg_pkg::addr_t v);
    for (int i = 0; i < 8; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic recv_byte(output logic [7:0] b);
    int waited;
    waited = 0;
    while (rx_rd == rx_wr && waited < RX_TIMEOUT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    b = 8'h00;
    assert (rx_rd != rx_wr) else begin
      $display("No reply byte from the target within %0d cycles", RX_TIMEOUT);
      errors = errors + 1;
    end
    if (rx_rd != rx_wr) begin
      b     = rx_log[rx_rd];
      rx_rd = rx_rd + 1;
    end
  endtask

  task automatic expect_byte(input string what, input logic [7:0] exp);
    logic [7:0] got;
    recv_byte(got);
    assert (got === exp) else begin
      $display("Fail uart_tx_o %s: expected 0x%02h, got 0x%02h", what, exp, got);
      errors = errors + 1;
    end
  endtask

  task automatic host_write(input uart_dbg_pkg::addr_t addr, input int len);
    send_byte(`DBG_CMD_WRITE);
    send_field(addr);
    send_field(64'(len));
    expect_byte("write ACK", `DBG_ACK);
    for (int i = 0; i < len; i++) begin
      send_byte(payload[i]);
    end
    expect_byte("write EOT", `DBG_EOT);
  endtask

  task automatic host_read(input uart_dbg_pkg::addr_t addr, input int len);
    send_byte(`DBG_CMD_READ);
    send_field(addr);
    send_field(64'(len));
    expect_byte("read ACK", `DBG_ACK);
    for (int i = 0; i < len; i++) begin
      expect_byte("read data", payload[i]);
    end
    expect_byte("read EOT", `DBG_EOT);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors + frame_errs == errs_before) begin
      $display("Test %s: ok", name);
      n_pass = n_pass + 1;
    end else begin
      $display("Test %s: failed", name);
      n_fail = n_fail + 1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    int                  mark;
    int                  pulses_before;
    uart_dbg_pkg::addr_t entry;
    uart_dbg_pkg::code_t code;

    clk         = 1'b0;
    rst_n_i     = 1'b0;
    uart_rx_i   = 1'b1;
    eoc_i       = 1'b0;
    exit_code_i = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    mark = errors + frame_errs;
    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      assert (uart_tx_o === 1'b1 && exec_o === 1'b0) else begin
        $display("Fail uart_tx_o/exec_o after reset: expected 0x1/0x0, got 0x%h/0x%h",
                 uart_tx_o, exec_o);
        errors = errors + 1;
      end
    end
    end_test("reset state", mark);

    mark = errors + frame_errs;
    send_byte(`DBG_ACK);
    expect_byte("challenge reply", `DBG_ACK);
    repeat (3 * 10 * CPB) @(negedge clk);
    assert (rx_rd == rx_wr) else begin
      $display("Target sent more than one byte after the challenge");
      errors = errors + 1;
    end
    end_test("acknowledge challenge", mark);

    mark = errors + frame_errs;
    for (int i = 0; i < 16; i++) begin
      payload[i] = rand_byte();
    end
    host_write(64'h20, 16);
    host_read(64'h20, 16);
    end_test("write then read back", mark);

    mark = errors + frame_errs;
    payload[0] = rand_byte();
    host_write(64'h1_0000_0105, 1);
    host_read(64'h05, 1);
    end_test("address wrap", mark);

    mark = errors + frame_errs;
    entry         = {$random(seed), $random(seed)};
    pulses_before = exec_pulses;
    send_byte(`DBG_CMD_EXEC);
    send_field(entry);
    expect_byte("execute ACK", `DBG_ACK);
    assert (exec_pulses - pulses_before == 1) else begin
      $display("Fail exec_o high cycles: expected 0x1, got 0x%h",
               exec_pulses - pulses_before);
      errors = errors + 1;
    end
    assert (exec_seen === entry) else begin
      $display("Fail exec_addr_o: expected 0x%016h, got 0x%016h", entry, exec_seen);
      errors = errors + 1;
    end
    end_test("execute", mark);

    mark = errors + frame_errs;
    code = $random(seed);
    @(posedge clk);
    #1;
    eoc_i       = 1'b1;
    exit_code_i = code;
    @(posedge clk);
    #1;
    eoc_i = 1'b0;
    expect_byte("EOC code", `DBG_EOC);
    for (int i = 0; i < 4; i++) begin
      expect_byte("exit code byte", code[8*i +: 8]);
    end
    end_test("end of computation", mark);

    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && errors + frame_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/uart_dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/dbg_mem.sv
hdl/uart_dbg_engine.sv
hdl/uart_dbg_top.sv
tb/tb_uart_dbg.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the UART debug server testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_uart_dbg -Mdir obj_dir -o sim_tb_uart_dbg
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_uart_dbg > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
fi
exit 1
